/* src/obj_video_settings.svh */
//--------------------
// object engine constants, positions live in a 10-bit screen space
// line start count assumes hdump steps once per clock
//--------------------
`ifndef OBJ_VIDEO_SETTINGS_SVH
`define OBJ_VIDEO_SETTINGS_SVH

// frame table depth, 1024 entries
`define OBJ_TABLE_AW 10

// hdump value that starts a new line
`define OBJ_LINE_START 9'h1d0

// fixed offsets added to every object position
`define OBJ_XOFS 10'h40
`define OBJ_YOFS 10'h10

// color index that is never written to the buffer
`define OBJ_TRANSP 4'hf

`endif

/* src/obj_video_pkg.sv */
//--------------------
// shared types of the object engine
//--------------------
`default_nettype none

package obj_video_pkg;

    typedef struct packed {
        logic [2:0] prio;
        logic [2:0] rsv;
        logic [9:0] pos;
    } obj_xword_t;

    typedef struct packed {
        logic       last;   // end of table
        logic [1:0] bank;
        logic [2:0] rsv;
        logic [9:0] pos;
    } obj_yword_t;

    typedef struct packed {
        logic [3:0] rows;     // tile rows minus one
        logic [3:0] cols;     // tile columns minus one
        logic       absolute; // scroll offsets not applied
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } obj_attr_t;

    typedef struct packed {
        obj_xword_t  x;
        obj_yword_t  y;
        logic [15:0] code;
        obj_attr_t   attr;
    } obj_entry_t;

    typedef struct packed {
        logic [15:0] code;
        logic [3:0]  vsub;
        logic        hflip;
        logic [4:0]  pal;
        logic [2:0]  prio;
        logic [1:0]  bank;
        logic [8:0]  hpos;
    } draw_req_t;

    typedef struct packed {
        logic [2:0] prio;
        logic [4:0] pal;
        logic [3:0] color;
    } obj_pixel_t;

    // end flag in y, or an attr high byte of ff
    function automatic logic entry_is_end(obj_entry_t e);
        return e.y.last || ({e.attr.rows, e.attr.cols} == 8'hff);
    endfunction

endpackage

`default_nettype wire

/* src/obj_frame_table.sv */
//--------------------
// read during write to one address returns the old entry
//--------------------
`timescale 1ns/10ps
`default_nettype none

`include "obj_video_settings.svh"

module obj_frame_table (
    input  logic                          clk,
    input  logic                          table_we,
    input  logic [`OBJ_TABLE_AW-1:0]      table_addr_w,
    input  obj_video_pkg::obj_entry_t     table_din,
    input  logic [`OBJ_TABLE_AW-1:0]      scan_addr,
    output obj_video_pkg::obj_entry_t     scan_entry
);

    obj_video_pkg::obj_entry_t mem [0:(1 << `OBJ_TABLE_AW)-1];

    // host side
    always_ff @(posedge clk) begin
        if (table_we) begin
            mem[table_addr_w] <= table_din;
        end
    end

    // scanner side, one cycle latency
    always_ff @(posedge clk) begin
        scan_entry <= mem[scan_addr];
    end

endmodule

`default_nettype wire

/* src/obj_tile_match.sv */
//--------------------
// results appear one cycle after the entry and hold while cen is low
// object height wraps at 1024 lines
//--------------------
`timescale 1ns/10ps
`default_nettype none

module obj_tile_match (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen,
    input  obj_video_pkg::obj_entry_t entry,
    input  logic [8:0]                vrender_l,
    output logic                      hit,
    output logic [3:0]                vsub,
    output logic [15:0]               row_code
);

    logic [9:0] dy;
    logic       in_span;
    logic       is_end;
    logic [3:0] m;

    assign is_end = obj_video_pkg::entry_is_end(entry);

    // distance from the object top wraps high when negative
    assign dy      = {1'b0, vrender_l} - entry.y.pos;
    assign in_span = (dy[9:8] == 2'b00) && (dy[7:4] <= entry.attr.rows);

    // tile row counted from the bottom when flipped
    assign m = entry.attr.vflip ? entry.attr.rows - dy[7:4] : dy[7:4];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hit <= 1'b0;
        end else if (cen) begin
            hit <= in_span && !is_end;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            vsub     <= entry.attr.vflip ? ~dy[3:0] : dy[3:0];
            row_code <= entry.code + {8'd0, m, 4'd0}; // rows are 16 codes apart
        end
    end

    a_no_end_hit: assert property (
        @(posedge clk) disable iff (rst)
        cen && (entry.y.last || entry.attr[15:8] == 8'hff) |=> !hit
    ) else $error("tile match hit on an end-of-table entry");

endmodule

`default_nettype wire

/* src/obj_line_scan.sv */
//--------------------
// walks the table once per line, drops whatever is left at the next line
// entries sit in read, offset, match and issue stages
//--------------------
`timescale 1ns/10ps
`default_nettype none

`include "obj_video_settings.svh"

module obj_line_scan (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [8:0]                hdump,
    input  logic [8:0]                vrender,
    input  logic [9:0]                off_x,
    input  logic [9:0]                off_y,
    output logic                      line,
    output logic [`OBJ_TABLE_AW-1:0]  scan_addr,
    input  obj_video_pkg::obj_entry_t scan_entry,
    output logic                      draw_start,
    output obj_video_pkg::draw_req_t  draw_req,
    input  logic                      draw_idle
);

    logic                     hstart;
    logic                     hstart_l;
    logic                     line_start;
    logic [8:0]               vrender_l;
    logic [`OBJ_TABLE_AW-1:0] addr;     // address of the entry now on scan_entry
    logic                     walking;
    logic                     rd_end;
    logic                     consume;
    logic                     st3_live;
    logic                     st4_live;
    logic                     hit_raw;
    logic                     hit;
    logic [3:0]               vsub;
    logic [15:0]              row_code;
    logic [3:0]               n;        // column being issued
    logic [3:0]               subn;
    logic [9:0]               effx;
    logic                     col_skip;
    logic                     can_issue;
    logic                     last_col;
    logic                     step;
    logic                     stall;
    logic                     start_d;

    obj_video_pkg::obj_entry_t st3;
    obj_video_pkg::obj_entry_t st4;

    assign hstart     = hdump == `OBJ_LINE_START;
    assign line_start = hstart && !hstart_l;

    assign rd_end    = obj_video_pkg::entry_is_end(scan_entry);
    assign consume   = walking && !stall;
    // the same address is read again while stalled
    assign scan_addr = line_start ? '0 : (consume ? addr + 1'd1 : addr);

    obj_tile_match u_tile_match (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cen       ( ~stall    ),
        .entry     ( st3       ),
        .vrender_l ( vrender_l ),
        .hit       ( hit_raw   ),
        .vsub      ( vsub      ),
        .row_code  ( row_code  )
    );

    // column placement mirrors under hflip, codes stay in order
    assign hit       = hit_raw && st4_live;
    assign subn      = st4.attr.hflip ? st4.attr.cols - n : n;
    assign effx      = st4.x.pos + {2'b00, subn, 4'd0};
    assign col_skip  = effx[9];
    assign can_issue = draw_idle && !draw_start && !start_d;
    assign last_col  = n == st4.attr.cols;
    assign step      = hit && (col_skip || can_issue);
    assign stall     = hit && !(step && last_col);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hstart_l   <= 1'b0;
            line       <= 1'b0;
            addr       <= '0;
            walking    <= 1'b0;
            st3_live   <= 1'b0;
            st4_live   <= 1'b0;
            n          <= '0;
            draw_start <= 1'b0;
            start_d    <= 1'b0;
        end else begin
            hstart_l <= hstart;
            start_d  <= draw_start;
            addr     <= scan_addr;
            if (consume && (rd_end || &addr)) begin
                walking <= 1'b0; // last address is still drawn
            end
            if (!stall) begin
                st3_live <= walking && !rd_end;
                st4_live <= st3_live;
            end
            draw_start <= step && !col_skip;
            if (step) begin
                n <= last_col ? 4'd0 : n + 4'd1;
            end
            // new line wins over everything above
            if (line_start) begin
                line       <= ~line;
                walking    <= 1'b1;
                st3_live   <= 1'b0;
                st4_live   <= 1'b0;
                n          <= '0;
                draw_start <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_start) begin
            vrender_l <= vrender;
        end
        if (!stall) begin
            st3       <= scan_entry;
            st3.x.pos <= scan_entry.x.pos + `OBJ_XOFS -
                         (scan_entry.attr.absolute ? 10'd0 : off_x);
            st3.y.pos <= scan_entry.y.pos + `OBJ_YOFS -
                         (scan_entry.attr.absolute ? 10'd0 : off_y);
            st4       <= st3;
        end
        if (step) begin
            draw_req <= '{
                code:  row_code + {12'd0, n},
                vsub:  vsub,
                hflip: st4.attr.hflip,
                pal:   st4.attr.pal,
                prio:  st4.x.prio,
                bank:  st4.y.bank,
                hpos:  effx[8:0]
            };
        end
    end

    a_start_pulse: assert property (
        @(posedge clk) disable iff (rst)
        draw_start |=> !draw_start
    ) else $error("draw_start held for two cycles");

endmodule

`default_nettype wire

/* src/obj_tile_draw.sv */
//--------------------
// one tile row per request, pixels past column 511 are clipped
// rom_addr is bank, code and vsub
//--------------------
`timescale 1ns/10ps
`default_nettype none

`include "obj_video_settings.svh"

module obj_tile_draw (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     draw_start,
    input  obj_video_pkg::draw_req_t draw_req,
    output logic                     draw_idle,
    output logic                     rom_cs,
    output logic [21:0]              rom_addr,
    input  logic [63:0]              rom_data,
    input  logic                     rom_ok,
    output logic                     wr_en,
    output logic [8:0]               wr_addr,
    output obj_video_pkg::obj_pixel_t wr_pixel,
    input  obj_video_pkg::obj_pixel_t wr_busy_pixel
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        WRITE
    } state_t;

    state_t                   state;
    obj_video_pkg::draw_req_t req;
    logic [63:0]              data;  // pixel shifter
    logic [3:0]               cnt;
    logic [9:0]               col;
    logic [3:0]               color;

    assign draw_idle = state == IDLE;
    assign rom_addr  = {req.bank, req.code, req.vsub};

    // leftmost pixel in the low nibble, taken from the top when flipped
    assign color    = req.hflip ? data[63:60] : data[3:0];
    assign col      = {1'b0, req.hpos} + {6'd0, cnt};
    assign wr_addr  = col[8:0];
    assign wr_pixel = '{prio: req.prio, pal: req.pal, color: color};
    assign wr_en    = (state == WRITE) && !col[9] &&
                      (color != `OBJ_TRANSP) &&
                      (wr_busy_pixel.color == `OBJ_TRANSP); // first writer keeps the spot

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            rom_cs <= 1'b0;
            cnt    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (draw_start) begin
                        state  <= FETCH;
                        rom_cs <= 1'b1;
                    end
                end
                FETCH: begin
                    if (rom_ok) begin
                        state  <= WRITE;
                        rom_cs <= 1'b0;
                        cnt    <= '0;
                    end
                end
                WRITE: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd15) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (draw_start && state == IDLE) begin
            req <= draw_req;
        end
        if (state == FETCH && rom_ok) begin
            data <= rom_data;
        end else if (state == WRITE) begin
            data <= req.hflip ? data << 4 : data >> 4;
        end
    end

    a_rom_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> $stable(rom_addr)
    ) else $error("rom_addr moved during a pending fetch");

endmodule

`default_nettype wire

/* src/obj_line_buffer.sv */
//--------------------
// halves power up transparent, hdump must step once per clock
// writes during the toggle cycle are dropped
//--------------------
`timescale 1ns/10ps
`default_nettype none

`include "obj_video_settings.svh"

module obj_line_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      line,
    input  logic                      wr_en,
    input  logic [8:0]                wr_addr,
    input  obj_video_pkg::obj_pixel_t wr_pixel,
    output obj_video_pkg::obj_pixel_t wr_busy_pixel,
    input  logic [8:0]                hdump,
    output obj_video_pkg::obj_pixel_t pixel
);

    localparam obj_video_pkg::obj_pixel_t CLEAR_PIXEL = '{
        prio:  3'd0,
        pal:   5'd0,
        color: `OBJ_TRANSP
    };

    logic                      rd_half;
    obj_video_pkg::obj_pixel_t peek  [2];
    obj_video_pkg::obj_pixel_t rdata [2];

    // on the toggle cycle line still points at the half that gets read next
    assign rd_half = (hdump == `OBJ_LINE_START) ? line : ~line;

    for (genvar g = 0; g < 2; g++) begin : g_half
        obj_video_pkg::obj_pixel_t mem [0:511] = '{default: CLEAR_PIXEL};

        always_ff @(posedge clk) begin
            if (rd_half == 1'(g)) begin
                mem[hdump] <= CLEAR_PIXEL; // cleared behind the read
            end else if (wr_en && line == 1'(g)) begin
                mem[wr_addr] <= wr_pixel;
            end
        end

        assign peek[g]  = mem[wr_addr];
        assign rdata[g] = mem[hdump];
    end

    assign wr_busy_pixel = peek[line]; // occupancy seen by the renderer

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pixel <= CLEAR_PIXEL;
        end else begin
            pixel <= rdata[rd_half];
        end
    end

endmodule

`default_nettype wire

/* src/obj_video.sv */
//--------------------
// object line engine, table in, one line of pixels out per line
//--------------------
`timescale 1ns/10ps
`default_nettype none

`include "obj_video_settings.svh"

module obj_video (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [8:0]                hdump,
    input  logic [8:0]                vrender,
    input  logic [9:0]                off_x,
    input  logic [9:0]                off_y,
    input  logic                      table_we,
    input  logic [`OBJ_TABLE_AW-1:0]  table_addr_w,
    input  obj_video_pkg::obj_entry_t table_din,
    output logic                      rom_cs,
    output logic [21:0]               rom_addr,
    input  logic [63:0]               rom_data,
    input  logic                      rom_ok,
    output logic                      line,
    output obj_video_pkg::obj_pixel_t pixel
);

    logic [`OBJ_TABLE_AW-1:0]  scan_addr;
    obj_video_pkg::obj_entry_t scan_entry;
    logic                      draw_start;
    obj_video_pkg::draw_req_t  draw_req;
    logic                      draw_idle;
    logic                      wr_en;
    logic [8:0]                wr_addr;
    obj_video_pkg::obj_pixel_t wr_pixel;
    obj_video_pkg::obj_pixel_t wr_busy_pixel;

    obj_frame_table u_table (
        .clk          ( clk          ),
        .table_we     ( table_we     ),
        .table_addr_w ( table_addr_w ),
        .table_din    ( table_din    ),
        .scan_addr    ( scan_addr    ),
        .scan_entry   ( scan_entry   )
    );

    obj_line_scan u_scan (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .hdump      ( hdump      ),
        .vrender    ( vrender    ),
        .off_x      ( off_x      ),
        .off_y      ( off_y      ),
        .line       ( line       ),
        .scan_addr  ( scan_addr  ),
        .scan_entry ( scan_entry ),
        .draw_start ( draw_start ),
        .draw_req   ( draw_req   ),
        .draw_idle  ( draw_idle  )
    );

    obj_tile_draw u_draw (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .draw_start    ( draw_start    ),
        .draw_req      ( draw_req      ),
        .draw_idle     ( draw_idle     ),
        .rom_cs        ( rom_cs        ),
        .rom_addr      ( rom_addr      ),
        .rom_data      ( rom_data      ),
        .rom_ok        ( rom_ok        ),
        .wr_en         ( wr_en         ),
        .wr_addr       ( wr_addr       ),
        .wr_pixel      ( wr_pixel      ),
        .wr_busy_pixel ( wr_busy_pixel )
    );

    obj_line_buffer u_buffer (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .line          ( line          ),
        .wr_en         ( wr_en         ),
        .wr_addr       ( wr_addr       ),
        .wr_pixel      ( wr_pixel      ),
        .wr_busy_pixel ( wr_busy_pixel ),
        .hdump         ( hdump         ),
        .pixel         ( pixel         )
    );

endmodule

`default_nettype wire

/* tests/obj_video_tb.sv */
//--------------------
// frames use the first 16 table entries and load late in a line
// the model image of a line is shown on the following line
//--------------------
`timescale 1ns/10ps
`default_nettype none

`include "obj_video_settings.svh"

module obj_video_tb;

    localparam logic [31:0] SEED        = 32'h7732_2cfc;
    localparam int          TOTAL_LINES = 60;
    localparam logic [11:0] CLEAR       = {3'd0, 5'd0, `OBJ_TRANSP};

    logic                      clk;
    logic                      rst;
    logic [8:0]                hdump;
    logic [8:0]                vrender;
    logic [9:0]                off_x;
    logic [9:0]                off_y;
    logic                      table_we;
    logic [`OBJ_TABLE_AW-1:0]  table_addr_w;
    obj_video_pkg::obj_entry_t table_din;
    logic                      rom_cs;
    logic [21:0]               rom_addr;
    logic [63:0]               rom_data;
    logic                      rom_ok;
    logic                      line;
    obj_video_pkg::obj_pixel_t pixel;

    obj_video_pkg::obj_entry_t tbl [16];  // table as the scanner sees it
    obj_video_pkg::obj_entry_t nxt [16];  // frame waiting to be written
    logic                      stage_pending;
    logic [11:0]               shown [512];
    logic [11:0]               built [512];
    logic [11:0]               pend_exp;
    logic [31:0]               rnd_state;
    logic [31:0]               lat_state;
    int                        rom_wait;
    int                        errors;
    int                        test_err;
    int                        tests_run;
    int                        tests_failed;
    string                     test_name;

    obj_video u_obj_video (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .hdump        ( hdump        ),
        .vrender      ( vrender      ),
        .off_x        ( off_x        ),
        .off_y        ( off_y        ),
        .table_we     ( table_we     ),
        .table_addr_w ( table_addr_w ),
        .table_din    ( table_din    ),
        .rom_cs       ( rom_cs       ),
        .rom_addr     ( rom_addr     ),
        .rom_data     ( rom_data     ),
        .rom_ok       ( rom_ok       ),
        .line         ( line         ),
        .pixel        ( pixel        )
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = lcg(rnd_state);
        return rnd_state;
    endfunction

    function automatic int rand_range(input int n);
        logic [31:0] r;
        r = next_rand();
        return r[31:16] % n;
    endfunction

    // 16 pixels per ROM word hashed from the address
    function automatic logic [63:0] rom_word(input logic [21:0] addr);
        logic [31:0] s;
        logic [63:0] d;
        s = SEED ^ {10'd0, addr};
        d = '0;
        for (int i = 0; i < 4; i++) begin
            s = lcg(s);
            d = {d[47:0], s[31:16]};
        end
        return d;
    endfunction

    function automatic obj_video_pkg::obj_entry_t make_entry(
        input logic [15:0] xw, input logic [15:0] yw,
        input logic [15:0] cw, input logic [15:0] aw);
        return {xw, yw, cw, aw};
    endfunction

    function automatic obj_video_pkg::obj_entry_t end_entry();
        return make_entry(16'h0000, 16'h8000, 16'h0000, 16'hff00);
    endfunction

    task automatic check_value(input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %s: expected %h, actual %h", test_name, exp, act);
            test_err++;
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err  = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_err != 0) begin
            tests_failed++;
        end
        $display("test %s done with %0d errors", test_name, test_err);
    endtask

    // reference image of one line from the current table
    task automatic build_line(input logic [8:0] vr, input logic [9:0] ox, input logic [9:0] oy);
        obj_video_pkg::obj_entry_t e;
        logic [9:0]  ex;
        logic [9:0]  ey;
        logic [9:0]  dy;
        logic [9:0]  effx;
        logic [9:0]  col;
        logic [3:0]  m;
        logic [3:0]  vs;
        logic [3:0]  sub;
        logic [3:0]  colr;
        logic [15:0] code;
        logic [63:0] d;
        logic        done;
        for (int i = 0; i < 512; i++) begin
            built[i] = CLEAR;
        end
        done = 1'b0;
        for (int i = 0; i < 16 && !done; i++) begin
            e = tbl[i];
            if (e.y.last || {e.attr.rows, e.attr.cols} == 8'hff) begin
                done = 1'b1;
            end else begin
                ex = e.x.pos + `OBJ_XOFS - (e.attr.absolute ? 10'd0 : ox);
                ey = e.y.pos + `OBJ_YOFS - (e.attr.absolute ? 10'd0 : oy);
                dy = {1'b0, vr} - ey;
                if (dy < 16 * (e.attr.rows + 1)) begin
                    m  = e.attr.vflip ? e.attr.rows - dy[7:4] : dy[7:4];
                    vs = e.attr.vflip ? 4'd15 - dy[3:0] : dy[3:0];
                    for (int c = 0; c <= e.attr.cols; c++) begin
                        sub  = e.attr.hflip ? e.attr.cols - c : c;
                        effx = ex + {2'b00, sub, 4'd0};
                        if (effx < 512) begin
                            code = e.code + {8'd0, m, 4'd0} + c;
                            d    = rom_word({e.y.bank, code, vs});
                            for (int j = 0; j < 16; j++) begin
                                colr = e.attr.hflip ? d[4*(15-j) +: 4] : d[4*j +: 4];
                                col  = effx + j;
                                if (col < 512 && colr != `OBJ_TRANSP &&
                                    built[col][3:0] == `OBJ_TRANSP) begin
                                    built[col] = {e.x.prio, e.attr.pal, colr}; // first wins
                                end
                            end
                        end
                    end
                end
            end
        end
    endtask

    // runs one full line from the line start count and checks the previous line's image
    task automatic run_line(input logic [8:0] vr, input logic [9:0] ox, input logic [9:0] oy);
        logic [8:0] h;
        build_line(vr, ox, oy);
        for (int k = 0; k < 512; k++) begin
            @(posedge clk);
            #10;
            h     = `OBJ_LINE_START + k;
            hdump = h;
            if (k == 0) begin
                vrender = vr;
                off_x   = ox;
                off_y   = oy;
            end
            table_we = stage_pending && k >= 300 && k < 316; // walk is long over
            if (table_we) begin
                table_addr_w = k - 300;
                table_din    = nxt[k-300];
            end
            @(negedge clk);
            check_value(pend_exp, pixel);
            pend_exp = shown[h];
        end
        if (stage_pending) begin
            tbl           = nxt;
            stage_pending = 1'b0;
        end
        shown = built;
    endtask

    task automatic gen_random_frame(input logic [8:0] vr, input logic [9:0] ox,
                                    input logic [9:0] oy);
        logic [31:0] r;
        logic [31:0] r2;
        logic [3:0]  rows;
        logic [3:0]  cols;
        logic        ab;
        logic [9:0]  sx;
        logic [9:0]  sy;
        logic [9:0]  xp;
        logic [9:0]  yp;
        int          budget;
        int          n;
        for (int i = 0; i < 16; i++) begin
            nxt[i] = end_entry();
        end
        budget = 6;  // tile budget that lets every line finish
        n      = 1 + rand_range(4);
        for (int i = 0; i < n && budget > 0; i++) begin
            cols = rand_range(3);
            if (cols + 1 > budget) begin
                cols = budget - 1;
            end
            budget -= cols + 1;
            rows = rand_range(4);
            ab   = rand_range(2);
            sy   = {1'b0, vr} - rand_range(16 * (rows + 1) + 8);
            sx   = rand_range(560);
            xp   = sx - `OBJ_XOFS + (ab ? 10'd0 : ox);
            yp   = sy - `OBJ_YOFS + (ab ? 10'd0 : oy);
            r    = next_rand();
            r2   = next_rand();
            nxt[i] = make_entry({r[31:29], 3'b000, xp}, {1'b0, r[28:27], 3'b000, yp},
                                r2[31:16], {rows, cols, ab, r[26], r[25], r[24:20]});
        end
        stage_pending = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ROM with 1 to 4 cycles of latency
    initial begin
        lat_state = SEED;
        rom_wait  = -1;
        forever begin
            @(posedge clk);
            #10;
            if (rom_ok) begin
                rom_ok   = 1'b0;
                rom_wait = -1;
            end else if (rom_cs) begin
                if (rom_wait < 0) begin
                    lat_state = lcg(lat_state);
                    rom_wait  = lat_state[31:30];
                end
                if (rom_wait == 0) begin
                    rom_ok   = 1'b1;
                    rom_data = rom_word(rom_addr);
                end else begin
                    rom_wait--;
                end
            end
        end
    end

    initial begin
        #((TOTAL_LINES + 4) * 512 * 100);
        $display("timeout, the run did not reach its end");
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [8:0] vr;
        logic [9:0] ox;
        logic [9:0] oy;
        rst           = 1'b1;
        hdump         = '0;
        vrender       = '0;
        off_x         = '0;
        off_y         = '0;
        table_we      = 1'b0;
        table_addr_w  = '0;
        table_din     = '0;
        rom_data      = '0;
        rom_ok        = 1'b0;
        rnd_state     = SEED;
        stage_pending = 1'b0;
        pend_exp      = CLEAR;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        for (int i = 0; i < 512; i++) begin
            shown[i] = CLEAR;
        end
        for (int i = 0; i < 16; i++) begin
            tbl[i] = end_entry();
        end
        repeat (2) @(posedge clk);
        #10 rst = 1'b0;

        start_test("reset_state");
        for (int k = 0; k < `OBJ_LINE_START; k++) begin
            @(posedge clk);
            #10;
            hdump        = k;
            table_we     = k < 16;
            table_addr_w = k;
            table_din    = end_entry();
            @(negedge clk);
            check_value(CLEAR, pixel);
            check_value(0, line);
            check_value(0, rom_cs);
        end
        table_we = 1'b0;
        run_line(9'h020, 10'd0, 10'd0);
        end_test();

        start_test("single_tile");
        nxt = tbl;
        nxt[0] = make_entry(16'h6050, 16'h0030, 16'h0123, 16'h0003);
        stage_pending = 1'b1;
        run_line(9'h000, 10'd0, 10'd0);
        for (int i = 0; i < 8; i++) begin
            vr = (i < 4) ? 9'h03e + i : 9'h04a + i;
            run_line(vr, 10'd0, 10'd0);
        end
        end_test();

        start_test("flip_multi");
        nxt = tbl;
        nxt[0] = make_entry(16'h2020, 16'h2040, 16'h0400, 16'h2267); // vflip and hflip
        nxt[1] = make_entry(16'h4100, 16'h0048, 16'h0800, 16'h1128); // hflip only
        stage_pending = 1'b1;
        run_line(9'h000, 10'd0, 10'd0);
        for (int i = 0; i < 8; i++) begin
            run_line(9'h050 + 6 * i, 10'd0, 10'd0);
        end
        end_test();

        start_test("scroll_absolute");
        nxt = tbl;
        nxt[0] = make_entry(16'h0080, 16'h0060, 16'h0a00, 16'h1004);
        nxt[1] = make_entry(16'h0120, 16'h0060, 16'h0b00, 16'h1085); // absolute
        stage_pending = 1'b1;
        run_line(9'h000, 10'd0, 10'd0);
        run_line(9'h078, 10'h000, 10'h000);
        run_line(9'h078, 10'h010, 10'h008);
        run_line(9'h078, 10'h3f0, 10'h3f8);
        run_line(9'h078, 10'h020, 10'h004);
        end_test();

        start_test("end_and_overlap");
        nxt = tbl;
        nxt[0] = make_entry(16'h0090, 16'h0030, 16'h0c00, 16'h0001);
        nxt[1] = make_entry(16'h0098, 16'h0030, 16'h0c10, 16'h0002);
        nxt[2] = make_entry(16'h0000, 16'h0000, 16'h0000, 16'hff00);
        nxt[3] = make_entry(16'h0100, 16'h0030, 16'h0c20, 16'h0003); // past the end
        stage_pending = 1'b1;
        run_line(9'h000, 10'd0, 10'd0);
        run_line(9'h040, 10'd0, 10'd0);
        run_line(9'h045, 10'd0, 10'd0);
        run_line(9'h04a, 10'd0, 10'd0);
        end_test();

        start_test("random_frames");
        vr = rand_range(512);
        ox = rand_range(1024);
        oy = rand_range(1024);
        gen_random_frame(vr, ox, oy);
        run_line(9'h000, 10'd0, 10'd0);
        for (int i = 0; i < 20; i++) begin
            logic [8:0] vr_n;
            logic [9:0] ox_n;
            logic [9:0] oy_n;
            vr_n = rand_range(512);
            ox_n = rand_range(1024);
            oy_n = rand_range(1024);
            gen_random_frame(vr_n, ox_n, oy_n);
            run_line(vr, ox, oy);
            vr = vr_n;
            ox = ox_n;
            oy = oy_n;
        end
        run_line(9'h000, 10'd0, 10'd0); // shows the last random line
        end_test();

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* obj_video.f */
+incdir+src
src/obj_video_pkg.sv
src/obj_frame_table.sv
src/obj_tile_match.sv
src/obj_line_scan.sv
src/obj_tile_draw.sv
src/obj_line_buffer.sv
src/obj_video.sv
tests/obj_video_tb.sv

/* Bender.yml */
package:
  name: obj_video

export_include_dirs:
  - src

sources:
  - src/obj_video_pkg.sv
  - src/obj_frame_table.sv
  - src/obj_tile_match.sv
  - src/obj_line_scan.sv
  - src/obj_tile_draw.sv
  - src/obj_line_buffer.sv
  - src/obj_video.sv
  - target: test
    files:
      - tests/obj_video_tb.sv
